// ==== verilog/gameController_defs.svh ====
`ifndef GAMECONTROLLER_DEFS_SVH
`define GAMECONTROLLER_DEFS_SVH

// board columns, wall columns 0 and BOARD_WIDTH-1 included
`define BOARD_WIDTH 10

// board rows, row 0 at the top
`define BOARD_HEIGHT 12

// bits of one cell code
`define CELL_BITS 4

// gameclk cycles between gravity steps
`define DROP_DIVIDE 60

// leftmost column of the 4-wide spawn window
`define SPAWN_COL (`BOARD_WIDTH / 2 - 2)

`endif

// ==== verilog/gameControllerPkg.sv ====
`include "gameController_defs.svh"

package gameControllerPkg;

    // one board row of cell codes, column 0 in the lowest bit index
    typedef logic [0:`BOARD_WIDTH*`CELL_BITS-1] cellRow_t;

    // one board row of occupancy bits, column c at bit c
    typedef logic [0:`BOARD_WIDTH-1] occRow_t;

    // cell code of a piece kind
    // 0 empty, 1 T, 2 O, 3 J, 4 L, 5 Z, 6 S, 7 I
    typedef logic [`CELL_BITS-1:0] pieceKind_t;

    // bits 0..3 are row 0 columns a..d, bits 4..7 are row 1
    typedef logic [0:7] pieceShape_t;

    // drop FSM states
    typedef enum logic [1:0] {
        SPAWNING,
        FALLING,
        STORING,
        CLEARING
    } dropState_t;

endpackage

// ==== verilog/dropController.sv ====
`include "gameController_defs.svh"

module dropController (
    input  logic gameclk,
    input  logic rst,
    input  logic moveLeft,
    input  logic moveRight,
    input  logic spawnAck,
    input  logic canLeft,
    input  logic canRight,
    input  logic landed,
    input  logic lineFull,
    output logic spawnReq,
    output logic loadPiece,
    output logic shiftLeft,
    output logic shiftRight,
    output logic fallStep,
    output logic clearPiece,
    output logic mergePiece,
    output logic clearStep,
    output logic pieceActive
);

    localparam int countBits = $clog2(`DROP_DIVIDE);

    gameControllerPkg::dropState_t state;
    logic [countBits-1:0] dropCount;
    logic dropTick;

    // two synchronizer flops plus one for edge detection
    logic [2:0] leftSync;
    logic [2:0] rightSync;
    logic edgeLeft;
    logic edgeRight;

    // one move held over a gravity tick
    logic pendLeft;
    logic pendRight;
    logic wantLeft;
    logic wantRight;

    always_ff @(posedge gameclk) begin
        if (!rst) begin
            leftSync <= '0;
            rightSync <= '0;
        end else begin
            leftSync <= {leftSync[1:0], moveLeft};
            rightSync <= {rightSync[1:0], moveRight};
        end
    end

    assign edgeLeft = leftSync[1] & ~leftSync[2];
    assign edgeRight = rightSync[1] & ~rightSync[2];

    // a fresh press replaces the pending one, left wins a tie
    assign wantLeft = edgeLeft | (pendLeft & ~edgeRight);
    assign wantRight = ~edgeLeft & (edgeRight | pendRight);

    assign dropTick = (dropCount == countBits'(`DROP_DIVIDE - 1));

    always_ff @(posedge gameclk) begin
        if (!rst) begin
            state <= gameControllerPkg::SPAWNING;
            spawnReq <= 1'b0;
            dropCount <= '0;
            pendLeft <= 1'b0;
            pendRight <= 1'b0;
        end else begin
            case (state)
                gameControllerPkg::SPAWNING: begin
                    if (spawnReq && spawnAck) begin
                        spawnReq <= 1'b0;
                        dropCount <= '0;
                        state <= gameControllerPkg::FALLING;
                    end else if (!spawnReq && !spawnAck) begin
                        spawnReq <= 1'b1;
                    end
                end
                gameControllerPkg::FALLING: begin
                    if (dropTick) begin
                        dropCount <= '0;
                        if (landed) begin
                            state <= gameControllerPkg::STORING;
                        end
                    end else begin
                        dropCount <= dropCount + 1'b1;
                    end
                end
                gameControllerPkg::STORING: begin
                    state <= gameControllerPkg::CLEARING;
                end
                default: begin
                    if (!lineFull) begin
                        state <= gameControllerPkg::SPAWNING;
                    end
                end
            endcase

            // served or blocked moves are gone, a tick only delays them
            if (state == gameControllerPkg::FALLING && dropTick) begin
                pendLeft <= wantLeft;
                pendRight <= wantRight;
            end else begin
                pendLeft <= 1'b0;
                pendRight <= 1'b0;
            end
        end
    end

    assign loadPiece = (state == gameControllerPkg::SPAWNING) && spawnReq && spawnAck;
    assign shiftLeft = (state == gameControllerPkg::FALLING) && !dropTick && wantLeft && canLeft;
    assign shiftRight = (state == gameControllerPkg::FALLING) && !dropTick && wantRight
                        && canRight;
    assign fallStep = (state == gameControllerPkg::FALLING) && dropTick && !landed;
    assign mergePiece = (state == gameControllerPkg::STORING);
    assign clearPiece = (state == gameControllerPkg::STORING);
    assign clearStep = (state == gameControllerPkg::CLEARING) && lineFull;
    assign pieceActive = (state == gameControllerPkg::FALLING);

    // four-phase rule toward the generator
    spawnReqAfterAck: assert property (@(posedge gameclk) disable iff (!rst)
        $rose(spawnReq) |-> !spawnAck);

    pieceStrobesExclusive: assert property (@(posedge gameclk) disable iff (!rst)
        $onehot0({loadPiece, shiftLeft, shiftRight, fallStep, clearPiece}));

endmodule

// ==== verilog/pieceGenerator.sv ====
module pieceGenerator (
    input  logic                           gameclk,
    input  logic                           rst,
    input  logic                           spawnReq,
    output logic                           spawnAck,
    output gameControllerPkg::pieceKind_t  pieceKind,
    output gameControllerPkg::pieceShape_t pieceShape
);

    // shift left, feed bit 2 xor bit 1
    // from 1 this walks 1,2,5,3,7,6,4 and repeats
    logic [2:0] lfsr;

    always_ff @(posedge gameclk) begin
        if (!rst) begin
            lfsr <= 3'd1;
            spawnAck <= 1'b0;
        end else if (spawnReq && !spawnAck) begin
            spawnAck <= 1'b1;
        end else if (!spawnReq && spawnAck) begin
            // piece taken, move on to the next kind
            spawnAck <= 1'b0;
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    assign pieceKind = {1'b0, lfsr};

    // window columns a..d, row 0 in bits 0..3, row 1 in bits 4..7
    always_comb begin
        case (lfsr)
            3'd1:    pieceShape = 8'b0111_0010;
            3'd2:    pieceShape = 8'b0110_0110;
            3'd3:    pieceShape = 8'b0111_0001;
            3'd4:    pieceShape = 8'b0111_0100;
            3'd5:    pieceShape = 8'b0110_0011;
            3'd6:    pieceShape = 8'b0011_0110;
            default: pieceShape = 8'b1111_0000;
        endcase
    end

    // an empty kind would spawn an invisible piece
    kindNeverEmpty: assert property (@(posedge gameclk) disable iff (!rst)
        spawnAck |-> pieceKind != '0);

endmodule

// ==== verilog/activePiece.sv ====
`include "gameController_defs.svh"

module activePiece (
    input  logic                           gameclk,
    input  logic                           rst,
    input  logic                           loadPiece,
    input  logic                           shiftLeft,
    input  logic                           shiftRight,
    input  logic                           fallStep,
    input  logic                           clearPiece,
    input  gameControllerPkg::pieceKind_t  pieceKind,
    input  gameControllerPkg::pieceShape_t pieceShape,
    input  gameControllerPkg::occRow_t     stackRows  [0:`BOARD_HEIGHT-1],
    output gameControllerPkg::occRow_t     pieceRows  [0:`BOARD_HEIGHT-1],
    output gameControllerPkg::cellRow_t    pieceCells [0:`BOARD_HEIGHT-1],
    output logic                           canLeft,
    output logic                           canRight,
    output logic                           landed
);

    gameControllerPkg::pieceKind_t kind;

    always_ff @(posedge gameclk) begin
        if (!rst) begin
            for (int r = 0; r < `BOARD_HEIGHT; r++) begin
                pieceRows[r] <= '0;
            end
        end else if (loadPiece) begin
            for (int r = 0; r < `BOARD_HEIGHT; r++) begin
                pieceRows[r] <= '0;
            end
            pieceRows[0][`SPAWN_COL +: 4] <= pieceShape[0:3];
            pieceRows[1][`SPAWN_COL +: 4] <= pieceShape[4:7];
        end else if (clearPiece) begin
            for (int r = 0; r < `BOARD_HEIGHT; r++) begin
                pieceRows[r] <= '0;
            end
        end else if (shiftLeft) begin
            // column 0 sits at the top bit index, so << moves left
            for (int r = 0; r < `BOARD_HEIGHT; r++) begin
                pieceRows[r] <= pieceRows[r] << 1;
            end
        end else if (shiftRight) begin
            for (int r = 0; r < `BOARD_HEIGHT; r++) begin
                pieceRows[r] <= pieceRows[r] >> 1;
            end
        end else if (fallStep) begin
            for (int r = `BOARD_HEIGHT - 1; r > 0; r--) begin
                pieceRows[r] <= pieceRows[r - 1];
            end
            pieceRows[0] <= '0;
        end
    end

    always_ff @(posedge gameclk) begin
        if (loadPiece) begin
            kind <= pieceKind;
        end
    end

    always_comb begin
        canLeft = 1'b1;
        canRight = 1'b1;
        landed = |pieceRows[`BOARD_HEIGHT-1];
        for (int r = 0; r < `BOARD_HEIGHT; r++) begin
            // wall columns are set in stackRows, so edges need no extra test
            if (|((pieceRows[r] << 1) & stackRows[r])) begin
                canLeft = 1'b0;
            end
            if (|((pieceRows[r] >> 1) & stackRows[r])) begin
                canRight = 1'b0;
            end
            for (int c = 0; c < `BOARD_WIDTH; c++) begin
                pieceCells[r][c*`CELL_BITS +: `CELL_BITS] = pieceRows[r][c] ? kind : '0;
            end
        end
        // resting on the stack
        for (int r = 0; r < `BOARD_HEIGHT - 1; r++) begin
            if (|(pieceRows[r] & stackRows[r + 1])) begin
                landed = 1'b1;
            end
        end
    end

    // the controller must only issue legal moves
    movesLegal: assert property (@(posedge gameclk) disable iff (!rst)
        (shiftLeft -> canLeft) && (shiftRight -> canRight) && (fallStep -> !landed));

endmodule

// ==== verilog/stackStore.sv ====
`include "gameController_defs.svh"

module stackStore (
    input  logic                        gameclk,
    input  logic                        rst,
    input  logic                        mergePiece,
    input  logic                        clearStep,
    input  gameControllerPkg::occRow_t  pieceRows  [0:`BOARD_HEIGHT-1],
    input  gameControllerPkg::cellRow_t pieceCells [0:`BOARD_HEIGHT-1],
    output gameControllerPkg::occRow_t  stackRows  [0:`BOARD_HEIGHT-1],
    output logic                        lineFull,
    output gameControllerPkg::cellRow_t cellRows   [0:`BOARD_HEIGHT-1]
);

    localparam int idxBits = $clog2(`BOARD_HEIGHT);

    // empty row, only the two wall columns occupied
    localparam gameControllerPkg::occRow_t wallRow = {1'b1, {(`BOARD_WIDTH-2){1'b0}}, 1'b1};

    gameControllerPkg::cellRow_t storeCells [0:`BOARD_HEIGHT-1];
    logic [idxBits-1:0] clearIdx;
    logic overlap;

    always_ff @(posedge gameclk) begin
        if (!rst) begin
            for (int r = 0; r < `BOARD_HEIGHT; r++) begin
                stackRows[r] <= wallRow;
                storeCells[r] <= '0;
            end
        end else if (mergePiece) begin
            for (int r = 0; r < `BOARD_HEIGHT; r++) begin
                stackRows[r] <= stackRows[r] | pieceRows[r];
                storeCells[r] <= storeCells[r] | pieceCells[r];
            end
        end else if (clearStep) begin
            // drop the lowest full row, everything above moves down one
            stackRows[0] <= wallRow;
            storeCells[0] <= '0;
            for (int r = 1; r < `BOARD_HEIGHT; r++) begin
                if (r <= clearIdx) begin
                    stackRows[r] <= stackRows[r - 1];
                    storeCells[r] <= storeCells[r - 1];
                end
            end
        end
    end

    always_comb begin
        lineFull = 1'b0;
        overlap = 1'b0;
        clearIdx = '0;
        for (int r = 0; r < `BOARD_HEIGHT; r++) begin
            // later hits are lower on the board
            if (&stackRows[r]) begin
                lineFull = 1'b1;
                clearIdx = idxBits'(r);
            end
            if (|(stackRows[r] & pieceRows[r])) begin
                overlap = 1'b1;
            end
            cellRows[r] = storeCells[r] | pieceCells[r];
        end
    end

    // landing checks upstream keep the piece off the stack
    mergeNoOverlap: assert property (@(posedge gameclk) disable iff (!rst)
        mergePiece |-> !overlap);

endmodule

// ==== verilog/gameController.sv ====
`include "gameController_defs.svh"

module gameController (
    input  logic                         gameclk,
    input  logic                         rst,
    input  logic                         moveLeft,
    input  logic                         moveRight,
    output gameControllerPkg::cellRow_t  cellRows [0:`BOARD_HEIGHT-1],
    output logic                         pieceActive
);

    // spawn handshake
    logic spawnReq;
    logic spawnAck;
    gameControllerPkg::pieceKind_t  pieceKind;
    gameControllerPkg::pieceShape_t pieceShape;

    // controller strobes
    logic loadPiece;
    logic shiftLeft;
    logic shiftRight;
    logic fallStep;
    logic clearPiece;
    logic mergePiece;
    logic clearStep;

    // status back to the controller
    logic canLeft;
    logic canRight;
    logic landed;
    logic lineFull;

    // piece and stack boards
    gameControllerPkg::occRow_t  pieceRows  [0:`BOARD_HEIGHT-1];
    gameControllerPkg::cellRow_t pieceCells [0:`BOARD_HEIGHT-1];
    gameControllerPkg::occRow_t  stackRows  [0:`BOARD_HEIGHT-1];

    dropController dropCtrl (
        .gameclk(gameclk), .rst(rst), .moveLeft(moveLeft), .moveRight(moveRight),
        .spawnAck(spawnAck), .canLeft(canLeft), .canRight(canRight), .landed(landed),
        .lineFull(lineFull), .spawnReq(spawnReq), .loadPiece(loadPiece),
        .shiftLeft(shiftLeft), .shiftRight(shiftRight), .fallStep(fallStep),
        .clearPiece(clearPiece), .mergePiece(mergePiece), .clearStep(clearStep),
        .pieceActive(pieceActive)
    );

    pieceGenerator pieceGen (
        .gameclk(gameclk), .rst(rst), .spawnReq(spawnReq), .spawnAck(spawnAck),
        .pieceKind(pieceKind), .pieceShape(pieceShape)
    );

    activePiece fallingPiece (
        .gameclk(gameclk), .rst(rst), .loadPiece(loadPiece), .shiftLeft(shiftLeft),
        .shiftRight(shiftRight), .fallStep(fallStep), .clearPiece(clearPiece),
        .pieceKind(pieceKind), .pieceShape(pieceShape), .stackRows(stackRows),
        .pieceRows(pieceRows), .pieceCells(pieceCells), .canLeft(canLeft),
        .canRight(canRight), .landed(landed)
    );

    stackStore stack (
        .gameclk(gameclk), .rst(rst), .mergePiece(mergePiece), .clearStep(clearStep),
        .pieceRows(pieceRows), .pieceCells(pieceCells), .stackRows(stackRows),
        .lineFull(lineFull), .cellRows(cellRows)
    );

endmodule

// ==== verification/boardModel.svh ====
`ifndef BOARDMODEL_SVH
`define BOARDMODEL_SVH

// stored stack codes, wall columns stay 0 here
int modelCode [0:`BOARD_HEIGHT-1][0:`BOARD_WIDTH-1];
// falling piece as four cells
int pieceR [0:3];
int pieceC [0:3];
int modelKind;
bit havePiece;
int modelClears;

function automatic void resetModel();
    for (int r = 0; r < `BOARD_HEIGHT; r++) begin
        for (int c = 0; c < `BOARD_WIDTH; c++) begin
            modelCode[r][c] = 0;
        end
    end
    modelKind = 1;
    havePiece = 1'b0;
    modelClears = 0;
endfunction

// 3-bit LFSR, shift left and feed bit 2 xor bit 1
function automatic int nextKind(input int k);
    logic [2:0] v;
    v = k[2:0];
    return int'({v[1:0], v[2] ^ v[1]});
endfunction

// two rows of window columns a..d, a in the top bit of each nibble
function automatic logic [7:0] shapeOf(input int kind);
    case (kind)
        1: return 8'b0111_0010;
        2: return 8'b0110_0110;
        3: return 8'b0111_0001;
        4: return 8'b0111_0100;
        5: return 8'b0110_0011;
        6: return 8'b0011_0110;
        default: return 8'b1111_0000;
    endcase
endfunction

function automatic void spawnModel();
    logic [7:0] s;
    int n;
    s = shapeOf(modelKind);
    n = 0;
    for (int i = 0; i < 8; i++) begin
        if (s[7 - i]) begin
            pieceR[n] = i / 4;
            pieceC[n] = `SPAWN_COL + i % 4;
            n++;
        end
    end
endfunction

function automatic bit occupied(input int r, input int c);
    return c == 0 || c == `BOARD_WIDTH - 1 || modelCode[r][c] != 0;
endfunction

function automatic int pieceCode(input int r, input int c);
    for (int i = 0; i < 4; i++) begin
        if (pieceR[i] == r && pieceC[i] == c) begin
            return modelKind;
        end
    end
    return 0;
endfunction

function automatic bit fits(input int dr, input int dc);
    for (int i = 0; i < 4; i++) begin
        if (pieceR[i] + dr >= `BOARD_HEIGHT || occupied(pieceR[i] + dr, pieceC[i] + dc)) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

// blocked moves leave the piece where it is
function automatic void moveModel(input int dc);
    if (fits(0, dc)) begin
        for (int i = 0; i < 4; i++) begin
            pieceC[i] += dc;
        end
    end
endfunction

function automatic void dropModel();
    while (fits(1, 0)) begin
        for (int i = 0; i < 4; i++) begin
            pieceR[i] += 1;
        end
    end
endfunction

function automatic bit rowFull(input int r);
    for (int c = 1; c < `BOARD_WIDTH - 1; c++) begin
        if (modelCode[r][c] == 0) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

// straight fall, store, then remove full rows from the bottom up
function automatic void landModel();
    dropModel();
    for (int i = 0; i < 4; i++) begin
        modelCode[pieceR[i]][pieceC[i]] = modelKind;
    end
    for (int r = `BOARD_HEIGHT - 1; r >= 0; r--) begin
        while (rowFull(r)) begin
            for (int k = r; k > 0; k--) begin
                for (int c = 0; c < `BOARD_WIDTH; c++) begin
                    modelCode[k][c] = modelCode[k - 1][c];
                end
            end
            for (int c = 0; c < `BOARD_WIDTH; c++) begin
                modelCode[0][c] = 0;
            end
            modelClears++;
        end
    end
endfunction

function automatic bit stackAtTop();
    for (int r = 0; r < 2; r++) begin
        for (int c = 1; c < `BOARD_WIDTH - 1; c++) begin
            if (modelCode[r][c] != 0) begin
                return 1'b1;
            end
        end
    end
    return 1'b0;
endfunction

function automatic gameControllerPkg::cellRow_t expectedRow(input int r);
    gameControllerPkg::cellRow_t row;
    row = '0;
    for (int c = 0; c < `BOARD_WIDTH; c++) begin
        row[c*`CELL_BITS +: `CELL_BITS] = `CELL_BITS'(modelCode[r][c] | pieceCode(r, c));
    end
    return row;
endfunction

// scans shifts -4..4 from a random start, keeps the lowest landing with few holes
function automatic int chooseShift(input int start);
    int saveR [0:3];
    int saveC [0:3];
    int best;
    int bestScore;
    int off;
    int score;
    saveR = pieceR;
    saveC = pieceC;
    best = 0;
    bestScore = -1000;
    for (int k = 0; k < 9; k++) begin
        off = (start + k) % 9 - 4;
        for (int n = 0; n < (off < 0 ? -off : off); n++) begin
            moveModel(off < 0 ? -1 : 1);
        end
        dropModel();
        score = 0;
        for (int i = 0; i < 4; i++) begin
            score += 2 * pieceR[i];
            if (pieceR[i] + 1 < `BOARD_HEIGHT && !occupied(pieceR[i] + 1, pieceC[i])
                    && pieceCode(pieceR[i] + 1, pieceC[i]) == 0) begin
                score -= 3;
            end
        end
        if (score > bestScore) begin
            bestScore = score;
            best = off;
        end
        pieceR = saveR;
        pieceC = saveC;
    end
    return best;
endfunction

`endif

// ==== verification/gameControllerTb.sv ====
`include "gameController_defs.svh"

module gameControllerTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pieceCount = 25;
    localparam int watchdogCycles = pieceCount * (`BOARD_HEIGHT + 2) * `DROP_DIVIDE + 2000;

    logic gameclk;
    logic rst;
    logic moveLeft;
    logic moveRight;
    gameControllerPkg::cellRow_t cellRows [0:`BOARD_HEIGHT-1];
    logic pieceActive;

    gameControllerPkg::cellRow_t expRows [0:`BOARD_HEIGHT-1];
    logic checkPending;
    logic [31:0] rngState;
    int errors;
    int testErrors;
    int testsPassed;
    int testsFailed;

    `include "boardModel.svh"

    gameController dut_i (
        .gameclk(gameclk), .rst(rst), .moveLeft(moveLeft), .moveRight(moveRight),
        .cellRows(cellRows), .pieceActive(pieceActive)
    );

    always #5 gameclk = ~gameclk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkRow(input string name, input int row,
                            input gameControllerPkg::cellRow_t exp,
                            input gameControllerPkg::cellRow_t act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s[%0d] expected %h actual %h", $time, name, row, exp, act);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            errors++;
            testErrors++;
        end
    endtask

    // compares the whole board on the negedge after a request
    always @(negedge gameclk) begin
        if (checkPending) begin
            checkFlag("pieceActive", 1'b1, pieceActive);
            for (int r = 0; r < `BOARD_HEIGHT; r++) begin
                checkRow("cellRows", r, expRows[r], cellRows[r]);
            end
            checkPending = 1'b0;
        end
    end

    task automatic requestCheck();
        for (int r = 0; r < `BOARD_HEIGHT; r++) begin
            expRows[r] = expectedRow(r);
        end
        @(posedge gameclk);
        #1 checkPending = 1'b1;
        wait (!checkPending);
    endtask

    task automatic applyReset();
        if ($time > 0) begin
            @(posedge gameclk);
            #1;
        end
        rst = 1'b0;
        repeat (2) @(posedge gameclk);
        #1 rst = 1'b1;
        resetModel();
    endtask

    task automatic waitSpawn();
        @(negedge gameclk);
        while (pieceActive) @(negedge gameclk);
        while (!pieceActive) @(negedge gameclk);
    endtask

    // lands the previous piece in the model, then checks the new spawn
    task automatic spawnStep(output bit topFull);
        waitSpawn();
        if (havePiece) begin
            landModel();
            modelKind = nextKind(modelKind);
        end
        topFull = stackAtTop();
        spawnModel();
        havePiece = 1'b1;
        requestCheck();
    endtask

    // 2 cycles high then 2 low
    task automatic press(input int dir);
        @(posedge gameclk);
        #1;
        if (dir < 0) begin
            moveLeft = 1'b1;
        end else begin
            moveRight = 1'b1;
        end
        repeat (2) @(posedge gameclk);
        #1;
        moveLeft = 1'b0;
        moveRight = 1'b0;
        @(posedge gameclk);
        moveModel(dir);
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            testsPassed++;
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    initial begin
        repeat (watchdogCycles) @(posedge gameclk);
        $display("watchdog: no progress after %0d cycles, the run is stopped", watchdogCycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        bit topFull;
        int shiftBy;
        logic wallBusy;
        gameclk = 1'b0;
        rst = 1'b0;
        moveLeft = 1'b0;
        moveRight = 1'b0;
        checkPending = 1'b0;
        rngState = 32'h7d2d;
        errors = 0;
        testErrors = 0;
        testsPassed = 0;
        testsFailed = 0;
        applyReset();

        spawnStep(topFull);
        finishTest("test 1 first spawn");

        // seven more spawns, the stack grows in the middle
        for (int p = 1; p < 8; p++) begin
            spawnStep(topFull);
        end
        finishTest("test 2 eight pieces without moves");

        applyReset();
        spawnStep(topFull);
        press(-1);
        requestCheck();
        press(1);
        requestCheck();
        finishTest("test 3 single left and right moves");

        spawnStep(topFull);
        repeat (6) press(1);
        requestCheck();
        wallBusy = 1'b0;
        for (int r = 0; r < `BOARD_HEIGHT; r++) begin
            wallBusy |= |cellRows[r][(`BOARD_WIDTH-1)*`CELL_BITS +: `CELL_BITS];
        end
        checkFlag("cellRows right wall column", 1'b0, wallBusy);
        finishTest("test 4 right wall stop");

        applyReset();
        for (int p = 0; p < 15; p++) begin
            spawnStep(topFull);
            if (topFull) begin
                $display("test 5: stack reached the top rows before piece %0d, ending early",
                         p + 1);
                break;
            end
            rngState = xorshift(rngState);
            shiftBy = chooseShift(int'(rngState % 9));
            for (int n = 0; n < (shiftBy < 0 ? -shiftBy : shiftBy); n++) begin
                press(shiftBy < 0 ? -1 : 1);
            end
            if (shiftBy != 0) begin
                requestCheck();
            end
        end
        if (modelClears == 0) begin
            $display("test 5: no full line was cleared during the random pieces");
            errors++;
            testErrors++;
        end
        finishTest("test 5 random moves with line clears");

        $display("tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== gameController.f ====
+incdir+verilog
+incdir+verification
verilog/gameControllerPkg.sv
verilog/dropController.sv
verilog/pieceGenerator.sv
verilog/activePiece.sv
verilog/stackStore.sv
verilog/gameController.sv
verification/gameControllerTb.sv
